//--- src/zports_pkg.sv
//////////////////////////////////////////////////////////////////////
// constants and types for the z80 port block, all in the zclk domain
//////////////////////////////////////////////////////////////////////

`default_nettype none

package zports_pkg;

	typedef logic [7:0] byte_t;  // data or address byte
	typedef logic [8:0] page_t;  // scroll offsets and line positions

	//////////////////////////////////////////////////////////////////////
	// low address byte of each port

	localparam byte_t PORT_FE    = 8'hFE;  // border, keyboard
	localparam byte_t PORT_F6    = 8'hF6;  // keyboard mirror
	localparam byte_t PORT_FD    = 8'hFD;  // #7FFD paging and AY
	localparam byte_t PORT_XT    = 8'hAF;  // extension registers #nnAF
	localparam byte_t PORT_F7    = 8'hF7;  // #EFF7
	localparam byte_t PORT_JOY   = 8'h1F;  // kempston
	localparam byte_t PORT_MOUSE = 8'hDF;
	localparam byte_t PORT_CFG   = 8'hBE;  // paging config read

	//////////////////////////////////////////////////////////////////////
	// extension register indexes, taken from the high address byte

	localparam byte_t XT_VCONF    = 8'd0;
	localparam byte_t XT_VPAGE    = 8'd1;
	localparam byte_t XT_XOFFS_L  = 8'd2;
	localparam byte_t XT_XOFFS_H  = 8'd3;
	localparam byte_t XT_YOFFS_L  = 8'd4;
	localparam byte_t XT_YOFFS_H  = 8'd5;
	localparam byte_t XT_TSCONF   = 8'd6;
	localparam byte_t XT_RAMPAGE0 = 8'd16;
	localparam byte_t XT_RAMPAGE1 = 8'd17;
	localparam byte_t XT_RAMPAGE2 = 8'd18;
	localparam byte_t XT_RAMPAGE3 = 8'd19;
	localparam byte_t XT_FMADDR   = 8'd21;
	localparam byte_t XT_TGPAGE   = 8'd22;
	localparam byte_t XT_SYSCONF  = 8'd32;
	localparam byte_t XT_MEMCONF  = 8'd33;
	localparam byte_t XT_HSINT    = 8'd34;
	localparam byte_t XT_VSINT_L  = 8'd35;
	localparam byte_t XT_VSINT_H  = 8'd36;
	localparam byte_t XT_IM2VECT  = 8'd37;

	//////////////////////////////////////////////////////////////////////
	// reset values

	localparam byte_t HINT_RESET  = 8'd1;
	localparam byte_t IM2_RESET   = 8'hFF;
	localparam byte_t VPAGE_RESET = 8'd5;
	// element n is the reset page of rampage n
	localparam logic [3:0][7:0] RAMPAGE_RESET = {8'd0, 8'd2, 8'd5, 8'd0};

	// a[11:8] selectors for #BE reads
	localparam logic [3:0] CFG_SEL_7FFD = 4'hA;
	localparam logic [3:0] CFG_SEL_EFF7 = 4'hB;

endpackage

`default_nettype wire

//--- src/io_strobe.sv
//////////////////////////////////////////////////////////////////////
// z80 control lines must be stable at the rising zclk edge
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_strobe (
	input  logic zclk,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic io_wr,
	output logic io_rd
);

	logic iowr_lvl;  // raw bus levels
	logic iord_lvl;
	logic iowr_prev;
	logic iord_prev;

	assign iowr_lvl = ~(iorq_n | wr_n);
	assign iord_lvl = ~(iorq_n | rd_n);

	// one pulse per bus cycle, pair has to drop before the next one
	always_ff @(posedge zclk)
	begin
		iowr_prev <= iowr_lvl;
		iord_prev <= iord_lvl;
		io_wr     <= iowr_lvl & ~iowr_prev;
		io_rd     <= iord_lvl & ~iord_prev;
	end

	// a z80 never reads and writes in the same i/o cycle
	a_no_rdwr: assert property (@(posedge zclk) !(io_wr && io_rd))
		else $error("io_wr and io_rd both high");

endmodule

`default_nettype wire

//--- src/port_decode.sv
//////////////////////////////////////////////////////////////////////
// pure decode of the address and bus lines, no state
// shadow mode is the dos input alone
//////////////////////////////////////////////////////////////////////

`default_nettype none

module port_decode import zports_pkg::*; (
	input  logic [15:0] a,
	input  logic        dos,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic        shadow,
	output logic        porthit,
	output logic        external_port,
	output logic        dataout,
	output logic        xt_sel,
	output logic        fe_sel,
	output logic        fd7_sel,
	output logic        eff7_sel,
	output logic        ay_bc1,
	output logic        ay_bdir
);

	byte_t loa;
	logic  fd_hit;
	logic  ay_reg;   // #FFFD, register select and data read
	logic  ay_data;  // #BFFD or #FFFD write

	assign loa    = a[7:0];
	assign shadow = dos;
	assign fd_hit = (loa == PORT_FD);

	//////////////////////////////////////////////////////////////////////
	// internal port hit

	always_comb
	begin
		case (loa)
			PORT_FE, PORT_XT, PORT_F6, PORT_FD, PORT_MOUSE, PORT_CFG:
				porthit = 1'b1;
			PORT_JOY, PORT_F7:
				porthit = !shadow;  // gone in dos mode
			default:
				porthit = 1'b0;
		endcase
	end

	assign external_port = fd_hit && (a[15:14] == 2'b11);

	// cpu reads our byte, except the AY which drives the bus itself
	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

	//////////////////////////////////////////////////////////////////////
	// write selects

	assign xt_sel   = (loa == PORT_XT);
	assign fe_sel   = (loa == PORT_FE);
	assign fd7_sel  = fd_hit && !a[15];
	assign eff7_sel = (loa == PORT_F7) && !a[12] && a[8] && !shadow;

	//////////////////////////////////////////////////////////////////////
	// AY bus controls

	assign ay_reg  = fd_hit && (a[15:14] == 2'b11);
	assign ay_data = fd_hit && a[15];  // #BFFD and #FFFD

	assign ay_bc1  = ay_reg & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = ay_data & ~iorq_n & ~wr_n;

endmodule

`default_nettype wire

//--- src/config_regs.sv
//////////////////////////////////////////////////////////////////////
// border and #nnAF registers, index is the high address byte
// border, tgpage, fmaddr[3:0] and tsconf[4:0] come up undefined
//////////////////////////////////////////////////////////////////////

`default_nettype none

module config_regs import zports_pkg::*; (
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       io_wr,
	input  logic       xt_sel,
	input  logic       fe_sel,
	input  byte_t      din,
	input  byte_t      xt_index,
	output logic [3:0] border,
	output byte_t      vconf,
	output page_t      x_offs,
	output page_t      y_offs,
	output byte_t      tsconf,
	output logic [4:0] fmaddr,
	output logic [4:0] tgpage,
	output byte_t      sysconf,
	output byte_t      memconf,
	output byte_t      hint_beg,
	output page_t      vint_beg,
	output byte_t      im2vect
);

	logic xt_wr;
	logic fe_wr;

	assign xt_wr = io_wr & xt_sel;
	assign fe_wr = io_wr & fe_sel;

	//////////////////////////////////////////////////////////////////////
	// extension registers

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vconf       <= '0;
			x_offs      <= '0;
			y_offs      <= '0;
			tsconf[7:5] <= '0;
			fmaddr[4]   <= 1'b0;
			sysconf     <= '0;
			memconf     <= '0;
			hint_beg    <= HINT_RESET;
			vint_beg    <= '0;
			im2vect     <= IM2_RESET;
		end
		else if (xt_wr)
		begin
			case (xt_index)
				XT_VCONF:    vconf         <= din;
				XT_XOFFS_L:  x_offs[7:0]   <= din;
				XT_XOFFS_H:  x_offs[8]     <= din[0];  // 9th bit only
				XT_YOFFS_L:  y_offs[7:0]   <= din;
				XT_YOFFS_H:  y_offs[8]     <= din[0];
				XT_TSCONF:   tsconf        <= din;
				XT_FMADDR:   fmaddr        <= din[4:0];
				XT_TGPAGE:   tgpage        <= din[7:3];
				XT_SYSCONF:  sysconf       <= din;
				XT_MEMCONF:  memconf       <= din;
				XT_HSINT:    hint_beg      <= din;
				XT_VSINT_L:  vint_beg[7:0] <= din;
				XT_VSINT_H:  vint_beg[8]   <= din[0];
				XT_IM2VECT:  im2vect       <= din;
				default:     ;  // paging indexes live in mem_paging
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// border colour, bit 7 is the extra border bit

	always_ff @(posedge zclk)
	begin
		if (fe_wr)
			border <= {din[7], din[2:0]};
	end

endmodule

`default_nettype wire

//--- src/mem_paging.sv
//////////////////////////////////////////////////////////////////////
// #7FFD and #nnAF share the page registers, #7FFD wins a tie
// the #7FFD lock clears only on reset
//////////////////////////////////////////////////////////////////////

`default_nettype none

module mem_paging import zports_pkg::*; (
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       io_wr,
	input  logic       xt_sel,
	input  logic       fd7_sel,
	input  logic       eff7_sel,
	input  byte_t      din,
	input  byte_t      xt_index,
	output byte_t      vpage,
	output byte_t      rampage0,
	output byte_t      rampage1,
	output byte_t      rampage2,
	output byte_t      rampage3,
	output byte_t      p7ffd,
	output byte_t      peff7_raw,
	output byte_t      peff7,
	output logic       pent1m_rom,
	output logic [5:0] pent1m_page,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	logic lock_7ffd;
	logic block1m;  // #EFF7 bit 2
	logic fd7_wr;
	logic xt_wr;

	assign block1m = peff7_raw[2];
	assign fd7_wr  = io_wr & fd7_sel & ~lock_7ffd;
	assign xt_wr   = io_wr & xt_sel;

	//////////////////////////////////////////////////////////////////////
	// #7FFD and page registers

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= '0;
			lock_7ffd <= 1'b0;
			vpage     <= VPAGE_RESET;
			rampage0  <= RAMPAGE_RESET[0];
			rampage1  <= RAMPAGE_RESET[1];
			rampage2  <= RAMPAGE_RESET[2];
			rampage3  <= RAMPAGE_RESET[3];
		end
		else if (fd7_wr)
		begin
			p7ffd <= din;
			if (din[5] && block1m)
				lock_7ffd <= 1'b1;  // 48k lock
			// pentagon 1M page bits only without the 1M block
			rampage3 <= {2'b00, block1m ? 3'b000 : {din[5], din[7:6]}, din[2:0]};
			vpage    <= {6'b000001, din[3], 1'b1};  // screen 5 or 7
		end
		else if (xt_wr)
		begin
			case (xt_index)
				XT_VPAGE:    vpage    <= din;
				XT_RAMPAGE0: rampage0 <= din;
				XT_RAMPAGE1: rampage1 <= din;
				XT_RAMPAGE2: rampage2 <= din;
				XT_RAMPAGE3: rampage3 <= din;
				default:     ;
			endcase
		end
	end

	// #EFF7, select already excludes shadow mode
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			peff7_raw <= '0;
		else if (io_wr && eff7_sel)
			peff7_raw <= din;
	end

	assign peff7 = block1m ? {peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]}
	                       : peff7_raw;

	assign pent1m_rom    = p7ffd[4];
	assign pent1m_page   = rampage3[5:0];
	assign pent1m_1m_on  = ~peff7_raw[2];
	assign pent1m_ram0_0 = peff7_raw[3];

	// once locked, #7FFD is frozen until reset
	a_lock_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		lock_7ffd |=> $stable(p7ffd))
		else $error("p7ffd changed while locked");

endmodule

`default_nettype wire

//--- src/read_mux.sv
//////////////////////////////////////////////////////////////////////
// byte returned to the cpu, decoded from the address alone
// unknown ports read as #FF
//////////////////////////////////////////////////////////////////////

`default_nettype none

module read_mux import zports_pkg::*; (
	input  logic [15:0] a,
	input  logic        shadow,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  byte_t       mus_in,
	input  byte_t       p7ffd,
	input  byte_t       peff7_raw,
	output byte_t       dout
);

	byte_t loa;
	byte_t cfg_byte;  // #BE readback

	assign loa = a[7:0];

	// paging config, selected by a[11:8]
	always_comb
	begin
		case (a[11:8])
			CFG_SEL_7FFD: cfg_byte = p7ffd;
			CFG_SEL_EFF7: cfg_byte = peff7_raw;  // unmasked value
			default:      cfg_byte = 8'hFF;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// port select

	always_comb
	begin
		case (loa)
			PORT_FE, PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_JOY:
				dout = shadow ? 8'hFF : {3'b000, kj_in};
			PORT_MOUSE:
				dout = mus_in;
			PORT_CFG:
				dout = cfg_byte;
			default:
				dout = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- src/zports_top.sv
//////////////////////////////////////////////////////////////////////
// z80 i/o port block, single zclk domain
// register outputs change two edges after the bus write starts
//////////////////////////////////////////////////////////////////////

`default_nettype none

module zports_top import zports_pkg::*; (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  byte_t       din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  byte_t       mus_in,
	output byte_t       dout,
	output logic        dataout,
	output logic        porthit,
	output logic        external_port,
	output logic        ay_bc1,
	output logic        ay_bdir,
	output logic [3:0]  border,
	output byte_t       vconf,
	output page_t       x_offs,
	output page_t       y_offs,
	output byte_t       tsconf,
	output logic [4:0]  fmaddr,
	output logic [4:0]  tgpage,
	output byte_t       sysconf,
	output byte_t       memconf,
	output byte_t       hint_beg,
	output page_t       vint_beg,
	output byte_t       im2vect,
	output byte_t       vpage,
	output byte_t       rampage0,
	output byte_t       rampage1,
	output byte_t       rampage2,
	output byte_t       rampage3,
	output byte_t       p7ffd,
	output byte_t       peff7,
	output logic        pent1m_rom,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0
);

	logic  io_wr;
	logic  shadow;
	logic  xt_sel;
	logic  fe_sel;
	logic  fd7_sel;
	logic  eff7_sel;
	byte_t peff7_raw;

	io_strobe io_strobe_i (
		.zclk   (zclk),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.io_wr  (io_wr),
		.io_rd  ()
	);

	port_decode port_decode_i (
		.a             (a),
		.dos           (dos),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.shadow        (shadow),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout),
		.xt_sel        (xt_sel),
		.fe_sel        (fe_sel),
		.fd7_sel       (fd7_sel),
		.eff7_sel      (eff7_sel),
		.ay_bc1        (ay_bc1),
		.ay_bdir       (ay_bdir)
	);

	// high address byte is the #nnAF index
	config_regs config_regs_i (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.io_wr    (io_wr),
		.xt_sel   (xt_sel),
		.fe_sel   (fe_sel),
		.din      (din),
		.xt_index (a[15:8]),
		.border   (border),
		.vconf    (vconf),
		.x_offs   (x_offs),
		.y_offs   (y_offs),
		.tsconf   (tsconf),
		.fmaddr   (fmaddr),
		.tgpage   (tgpage),
		.sysconf  (sysconf),
		.memconf  (memconf),
		.hint_beg (hint_beg),
		.vint_beg (vint_beg),
		.im2vect  (im2vect)
	);

	mem_paging mem_paging_i (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.io_wr         (io_wr),
		.xt_sel        (xt_sel),
		.fd7_sel       (fd7_sel),
		.eff7_sel      (eff7_sel),
		.din           (din),
		.xt_index      (a[15:8]),
		.vpage         (vpage),
		.rampage0      (rampage0),
		.rampage1      (rampage1),
		.rampage2      (rampage2),
		.rampage3      (rampage3),
		.p7ffd         (p7ffd),
		.peff7_raw     (peff7_raw),
		.peff7         (peff7),
		.pent1m_rom    (pent1m_rom),
		.pent1m_page   (pent1m_page),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	read_mux read_mux_i (
		.a         (a),
		.shadow    (shadow),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.p7ffd     (p7ffd),
		.peff7_raw (peff7_raw),
		.dout      (dout)
	);

endmodule

`default_nettype wire

//--- bench/zports_tb.sv
//////////////////////////////////////////////////////////////////////
// random z80 bus cycles against a model of the port rules, fixed seed
// registers without reset are compared only after their first write
//////////////////////////////////////////////////////////////////////

`default_nettype none

module zports_tb import zports_pkg::*; ();

	localparam int N_XT        = 200;
	localparam int N_PG_ROUNDS = 5;
	localparam int N_PG        = 40;
	localparam int N_RD        = 200;
	localparam int N_AY        = 100;
	localparam int CYC_PER_TXN = 3;  // two strobe cycles plus one idle
	localparam int TXN_TOTAL   = N_XT + N_PG_ROUNDS * N_PG + N_RD + N_AY
	                             + (N_PG_ROUNDS + 1) * CYC_PER_TXN;
	localparam int WATCHDOG    = 2 * TXN_TOTAL * CYC_PER_TXN * 8;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	byte_t       din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	byte_t       mus_in;
	byte_t       dout;
	logic        dataout;
	logic        porthit;
	logic        external_port;
	logic        ay_bc1;
	logic        ay_bdir;
	logic [3:0]  border;
	byte_t       vconf;
	page_t       x_offs;
	page_t       y_offs;
	byte_t       tsconf;
	logic [4:0]  fmaddr;
	logic [4:0]  tgpage;
	byte_t       sysconf;
	byte_t       memconf;
	byte_t       hint_beg;
	page_t       vint_beg;
	byte_t       im2vect;
	byte_t       vpage;
	byte_t       rampage0;
	byte_t       rampage1;
	byte_t       rampage2;
	byte_t       rampage3;
	byte_t       p7ffd;
	byte_t       peff7;
	logic        pent1m_rom;
	logic [5:0]  pent1m_page;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;

	// reference model state
	logic [3:0] m_border;
	byte_t      m_vconf;
	page_t      m_xoffs;
	page_t      m_yoffs;
	byte_t      m_tsconf;
	logic [4:0] m_fmaddr;
	logic [4:0] m_tgpage;
	byte_t      m_sysconf;
	byte_t      m_memconf;
	byte_t      m_hint;
	page_t      m_vint;
	byte_t      m_im2;
	byte_t      m_vpage;
	byte_t      m_rp [4];
	byte_t      m_p7ffd;
	byte_t      m_peff7_raw;
	logic       m_lock;
	logic       border_ok;  // written at least once
	logic       tsconf_ok;
	logic       fmaddr_ok;
	logic       tgpage_ok;

	integer seed = 32'h594b;
	int     errors;
	int     checks;
	int     err_mark;
	int     test_num;

	zports_top zports_top_i (.*);

	always #4 zclk = ~zclk;

	initial
	begin
		#(WATCHDOG);
		$display("timeout: no result after %0d time units", WATCHDOG);
		$display("sim failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic byte_t pick_xt_index(input int sel);
		case (sel)
			0:       return XT_VCONF;
			1:       return XT_VPAGE;
			2:       return XT_XOFFS_L;
			3:       return XT_XOFFS_H;
			4:       return XT_YOFFS_L;
			5:       return XT_YOFFS_H;
			6:       return XT_TSCONF;
			7:       return XT_RAMPAGE0;
			8:       return XT_RAMPAGE1;
			9:       return XT_RAMPAGE2;
			10:      return XT_RAMPAGE3;
			11:      return XT_FMADDR;
			12:      return XT_TGPAGE;
			13:      return XT_SYSCONF;
			14:      return XT_MEMCONF;
			15:      return XT_HSINT;
			16:      return XT_VSINT_L;
			17:      return XT_VSINT_H;
			default: return XT_IM2VECT;
		endcase
	endfunction

	function automatic byte_t pick_port(input int sel);
		case (sel)
			0:       return PORT_FE;
			1:       return PORT_F6;
			2:       return PORT_FD;
			3:       return PORT_XT;
			4:       return PORT_F7;
			5:       return PORT_JOY;
			6:       return PORT_MOUSE;
			default: return PORT_CFG;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
		test_num++;
		err_mark = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// model

	task automatic model_reset();
		m_vconf        = '0;
		m_xoffs        = '0;
		m_yoffs        = '0;
		m_tsconf[7:5]  = '0;
		m_fmaddr[4]    = 1'b0;
		m_sysconf      = '0;
		m_memconf      = '0;
		m_hint         = 8'd1;
		m_vint         = '0;
		m_im2          = 8'hFF;
		m_vpage        = 8'd5;
		m_rp[0]        = 8'd0;
		m_rp[1]        = 8'd5;
		m_rp[2]        = 8'd2;
		m_rp[3]        = 8'd0;
		m_p7ffd        = '0;
		m_peff7_raw    = '0;
		m_lock         = 1'b0;
	endtask

	task automatic model_write(input logic [15:0] addr, input byte_t d, input logic sh);
		byte_t lo;
		logic  blk;
		lo  = addr[7:0];
		blk = m_peff7_raw[2];  // 1 MB blocked
		if (lo == PORT_XT)
		begin
			case (addr[15:8])
				XT_VCONF:    m_vconf       = d;
				XT_VPAGE:    m_vpage       = d;
				XT_XOFFS_L:  m_xoffs[7:0]  = d;
				XT_XOFFS_H:  m_xoffs[8]    = d[0];
				XT_YOFFS_L:  m_yoffs[7:0]  = d;
				XT_YOFFS_H:  m_yoffs[8]    = d[0];
				XT_RAMPAGE0: m_rp[0]       = d;
				XT_RAMPAGE1: m_rp[1]       = d;
				XT_RAMPAGE2: m_rp[2]       = d;
				XT_RAMPAGE3: m_rp[3]       = d;
				XT_SYSCONF:  m_sysconf     = d;
				XT_MEMCONF:  m_memconf     = d;
				XT_HSINT:    m_hint        = d;
				XT_VSINT_L:  m_vint[7:0]   = d;
				XT_VSINT_H:  m_vint[8]     = d[0];
				XT_IM2VECT:  m_im2         = d;
				XT_TSCONF:
				begin
					m_tsconf  = d;
					tsconf_ok = 1'b1;
				end
				XT_FMADDR:
				begin
					m_fmaddr  = d[4:0];
					fmaddr_ok = 1'b1;
				end
				XT_TGPAGE:
				begin
					m_tgpage  = d[7:3];
					tgpage_ok = 1'b1;
				end
				default: ;
			endcase
		end
		if (lo == PORT_FE)
		begin
			m_border  = {d[7], d[2:0]};
			border_ok = 1'b1;
		end
		if (lo == PORT_FD && !addr[15] && !m_lock)
		begin
			m_p7ffd = d;
			if (d[5] && blk)
				m_lock = 1'b1;
			m_rp[3] = {2'b00, blk ? 3'b000 : {d[5], d[7], d[6]}, d[2:0]};
			m_vpage = 8'd5 + (d[3] ? 8'd2 : 8'd0);  // 4 + 2*d3 + 1
		end
		if (lo == PORT_F7 && !addr[12] && addr[8] && !sh)
			m_peff7_raw = d;
	endtask

	function automatic byte_t exp_peff7();
		return m_peff7_raw[2] ? (m_peff7_raw & 8'hB1) : m_peff7_raw;
	endfunction

	function automatic logic exp_porthit(input logic [15:0] addr, input logic sh);
		case (addr[7:0])
			PORT_FE, PORT_XT, PORT_F6, PORT_FD, PORT_MOUSE, PORT_CFG: return 1'b1;
			PORT_JOY, PORT_F7: return !sh;
			default: return 1'b0;
		endcase
	endfunction

	// read data for the current bus inputs
	function automatic byte_t exp_dout();
		case (a[7:0])
			PORT_FE, PORT_F6: return {1'b1, tape_read, 1'b0, keys_in};
			PORT_JOY:         return dos ? 8'hFF : {3'b000, kj_in};
			PORT_MOUSE:       return mus_in;
			PORT_CFG:
				if (a[11:8] == 4'hA)
					return m_p7ffd;
				else if (a[11:8] == 4'hB)
					return m_peff7_raw;
				else
					return 8'hFF;
			default:          return 8'hFF;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks and bus cycles

	task automatic check_regs();
		byte_t      ts_mask;
		logic [4:0] fm_mask;
		ts_mask = tsconf_ok ? 8'hFF : 8'hE0;
		fm_mask = fmaddr_ok ? 5'h1F : 5'h10;
		if (border_ok)
			check_val("border", 32'(border), 32'(m_border));
		if (tgpage_ok)
			check_val("tgpage", 32'(tgpage), 32'(m_tgpage));
		check_val("vconf", 32'(vconf), 32'(m_vconf));
		check_val("x_offs", 32'(x_offs), 32'(m_xoffs));
		check_val("y_offs", 32'(y_offs), 32'(m_yoffs));
		check_val("tsconf", 32'(tsconf & ts_mask), 32'(m_tsconf & ts_mask));
		check_val("fmaddr", 32'(fmaddr & fm_mask), 32'(m_fmaddr & fm_mask));
		check_val("sysconf", 32'(sysconf), 32'(m_sysconf));
		check_val("memconf", 32'(memconf), 32'(m_memconf));
		check_val("hint_beg", 32'(hint_beg), 32'(m_hint));
		check_val("vint_beg", 32'(vint_beg), 32'(m_vint));
		check_val("im2vect", 32'(im2vect), 32'(m_im2));
		check_val("vpage", 32'(vpage), 32'(m_vpage));
		check_val("rampage0", 32'(rampage0), 32'(m_rp[0]));
		check_val("rampage1", 32'(rampage1), 32'(m_rp[1]));
		check_val("rampage2", 32'(rampage2), 32'(m_rp[2]));
		check_val("rampage3", 32'(rampage3), 32'(m_rp[3]));
		check_val("p7ffd", 32'(p7ffd), 32'(m_p7ffd));
		check_val("peff7", 32'(peff7), 32'(exp_peff7()));
		check_val("pent1m_rom", 32'(pent1m_rom), 32'(m_p7ffd[4]));
		check_val("pent1m_page", 32'(pent1m_page), 32'(m_rp[3][5:0]));
		check_val("pent1m_1m_on", 32'(pent1m_1m_on), 32'(!m_peff7_raw[2]));
		check_val("pent1m_ram0_0", 32'(pent1m_ram0_0), 32'(m_peff7_raw[3]));
	endtask

	task automatic check_bus(input logic act, input logic is_wr);
		logic hit;
		logic ext;
		logic fd;
		fd  = (a[7:0] == PORT_FD);
		hit = exp_porthit(a, dos);
		ext = fd && (a[15:14] == 2'b11);  // #FFFD
		check_val("porthit", 32'(porthit), 32'(hit));
		check_val("external_port", 32'(external_port), 32'(ext));
		check_val("dataout", 32'(dataout), 32'(hit && act && !is_wr && !ext));
		check_val("ay_bc1", 32'(ay_bc1), 32'(ext && act));
		check_val("ay_bdir", 32'(ay_bdir), 32'(fd && a[15] && act && is_wr));
		check_val("dout", 32'(dout), 32'(exp_dout()));
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic bus_cycle(input logic [15:0] addr, input byte_t d, input logic act,
	                         input logic is_wr, input logic sh);
		logic [31:0] r;
		r         = rand_word();
		a         = addr;
		din       = d;
		dos       = sh;
		keys_in   = r[4:0];
		tape_read = r[5];
		kj_in     = r[10:6];
		mus_in    = r[18:11];
		iorq_n    = !act;
		wr_n      = !(act && is_wr);
		rd_n      = !(act && !is_wr);
		@(negedge zclk);
		check_bus(act, is_wr);
		@(negedge zclk);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		if (act && is_wr)
			model_write(addr, d, sh);
		@(negedge zclk);  // idle cycle, registers settled
		check_regs();
	endtask

	task automatic apply_reset();
		@(negedge zclk);
		rst_n = 1'b0;
		repeat (5) @(negedge zclk);
		rst_n = 1'b1;
		model_reset();
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence

	initial
	begin
		logic [31:0] r;
		byte_t       hi;
		byte_t       lo;
		logic        act;
		zclk      = 1'b0;
		rst_n     = 1'b0;
		a         = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = '0;
		tape_read = 1'b0;
		kj_in     = '0;
		mus_in    = '0;
		border_ok = 1'b0;
		tsconf_ok = 1'b0;
		fmaddr_ok = 1'b0;
		tgpage_ok = 1'b0;
		errors    = 0;
		checks    = 0;
		err_mark  = 0;
		test_num  = 1;

		apply_reset();
		check_regs();
		report_test("reset values");

		for (int i = 0; i < N_XT; i++)
		begin
			r = rand_word();
			bus_cycle({pick_xt_index(int'(r[7:0] % 8'd19)), PORT_XT}, r[15:8], 1'b1, 1'b1, r[16]);
		end
		report_test("extension writes");

		// reset every round, the lock would freeze #7FFD for good
		for (int k = 0; k < N_PG_ROUNDS; k++)
		begin
			apply_reset();
			for (int i = 0; i < N_PG; i++)
			begin
				r = rand_word();
				case (r[1:0])
					2'd0, 2'd1:
						bus_cycle({r[2] ? r[15:8] : {1'b0, r[14:8]}, PORT_FD}, r[31:24],
						          1'b1, 1'b1, r[4] & r[5]);
					2'd2:
						bus_cycle({r[3] ? 8'hEF : r[15:8], PORT_F7}, r[31:24],
						          1'b1, 1'b1, r[4] & r[5]);
					default:
						bus_cycle({r[10] ? XT_VPAGE : {6'd4, r[9:8]}, PORT_XT}, r[31:24],
						          1'b1, 1'b1, r[4] & r[5]);
				endcase
			end
		end
		report_test("paging writes");

		for (int i = 0; i < N_RD; i++)
		begin
			r   = rand_word();
			lo  = r[0] ? pick_port(int'(r[3:1])) : r[15:8];
			hi  = r[23:16];
			act = r[24] | r[25];  // some cycles with the bus idle
			if (lo == PORT_CFG && r[27])
				hi[3:0] = {3'b101, r[28]};
			bus_cycle({hi, lo}, r[31:24], act, 1'b0, r[26]);
		end
		report_test("reads");

		for (int i = 0; i < N_AY; i++)
		begin
			r = rand_word();
			case (r[1:0])
				2'd0:    bus_cycle({r[15:8], PORT_FE}, r[31:24], 1'b1, 1'b1, 1'b0);
				2'd1:    bus_cycle({2'b11, r[13:8], PORT_FD}, r[31:24], 1'b1, r[2], 1'b0);
				2'd2:    bus_cycle({2'b10, r[13:8], PORT_FD}, r[31:24], 1'b1, r[2], 1'b0);
				default: bus_cycle({r[15:8], PORT_FD}, r[31:24], 1'b1, 1'b0, 1'b0);
			endcase
		end
		report_test("border and AY");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
src/zports_pkg.sv
src/io_strobe.sv
src/port_decode.sv
src/config_regs.sv
src/mem_paging.sv
src/read_mux.sv
src/zports_top.sv
bench/zports_tb.sv

//--- Makefile
# Verilator build and run of the zports testbench

VERILATOR ?= verilator
TOP       ?= zports_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -j 0
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line shows up"
	@echo "  clean  remove the build directory"
	@echo "overridable: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
